// ==== Makefile ====
# verilator build and run of the decode stage testbench

SIM      := verilator
TOP      := tb_id_stage
FILELIST := id_stage.f
FLAGS    := --binary -j 0 --top-module $(TOP)

SRCS := $(filter %.sv,$(shell cat $(FILELIST))) $(wildcard *.svh)
BIN  := obj_dir/V$(TOP)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SRCS) $(FILELIST)
	$(SIM) $(FLAGS) -f $(FILELIST)

run: $(BIN)
	./$(BIN)

clean:
	rm -rf obj_dir

// ==== id_branch_unit.sv ====
// branch and jump resolution with condition, target and redirect to fetch
`include "id_stage_defines.svh"

module id_branch_unit import id_stage_pkg::*; (
  input  logic     i_valid,
  input  br_ctrl_t i_br_ctrl,
  input  xword_t   i_rs1data,
  input  xword_t   i_rs2data,
  input  xword_t   i_pc,
  input  xword_t   i_imm,
  input  xword_t   i_fetch_pc,
  output br_bus_t  o_br
);

  logic   cond;
  logic   br_sel;
  xword_t jalr_sum;
  xword_t target;

  always_comb begin
    case (i_br_ctrl.br_func)
      BR_EQ:   cond = (i_rs1data == i_rs2data);
      BR_NE:   cond = (i_rs1data != i_rs2data);
      BR_LT:   cond = ($signed(i_rs1data) < $signed(i_rs2data));
      BR_GE:   cond = ($signed(i_rs1data) >= $signed(i_rs2data));
      BR_LTU:  cond = (i_rs1data < i_rs2data);
      BR_GEU:  cond = (i_rs1data >= i_rs2data);
      default: cond = 1'b0;
    endcase
  end

  assign jalr_sum = i_rs1data + i_imm;
  assign target   = i_br_ctrl.jalr ? {jalr_sum[`ID_XLEN-1:1], 1'b0} : i_pc + i_imm;

  assign br_sel = i_br_ctrl.jal || i_br_ctrl.jalr || (i_br_ctrl.bren && cond);

  // no flush when fetch is already on the target
  assign o_br.taken  = i_valid && br_sel && (target != i_fetch_pc);
  assign o_br.target = target;

endmodule

// ==== id_decoder.sv ====
// rv64i decoder: register indices, sign-extended immediate and control fields
`include "id_stage_defines.svh"

module id_decoder import id_stage_pkg::*; (
  input  inst_u     i_inst,
  output gpr_addr_t o_rs1,
  output gpr_addr_t o_rs2,
  output gpr_addr_t o_rd,
  output xword_t    o_imm,
  output ds_ctrl_t  o_ctrl,
  output br_ctrl_t  o_br_ctrl
);

  logic [`ID_FUNCT3_WD-1:0] funct3;
  logic [6:0]               funct7;
  logic                     f7_zero;
  logic                     f7_alt;
  logic                     legal;
  xword_t                   imm_i;
  xword_t                   imm_s;
  xword_t                   imm_b;
  xword_t                   imm_u;
  xword_t                   imm_j;

  // alt selects sub for funct3 000 and sra for 101
  function automatic alu_op_e alu_op_of(input logic [`ID_FUNCT3_WD-1:0] f3, input logic alt);
    case (f3)
      3'b000:  alu_op_of = alt ? ALU_SUB : ALU_ADD;
      3'b001:  alu_op_of = ALU_SLL;
      3'b010:  alu_op_of = ALU_SLT;
      3'b011:  alu_op_of = ALU_SLTU;
      3'b100:  alu_op_of = ALU_XOR;
      3'b101:  alu_op_of = alt ? ALU_SRA : ALU_SRL;
      3'b110:  alu_op_of = ALU_OR;
      default: alu_op_of = ALU_AND;
    endcase
  endfunction

  assign funct3  = i_inst.r.funct3;
  assign funct7  = i_inst.r.funct7;
  assign f7_zero = (funct7 == 7'b0000000);
  assign f7_alt  = (funct7 == 7'b0100000);

  assign o_rs1 = i_inst.r.rs1;
  assign o_rs2 = i_inst.r.rs2;
  assign o_rd  = i_inst.u.rd;

  assign imm_i = {{(`ID_XLEN-12){funct7[6]}}, funct7, i_inst.r.rs2};
  assign imm_s = {{(`ID_XLEN-12){funct7[6]}}, funct7, i_inst.r.rd};
  assign imm_b = {{(`ID_XLEN-12){funct7[6]}}, i_inst.r.rd[0], funct7[5:0],
                  i_inst.r.rd[4:1], 1'b0};
  assign imm_u = {{(`ID_XLEN-32){i_inst.u.upper[19]}}, i_inst.u.upper, 12'b0};
  assign imm_j = {{(`ID_XLEN-20){i_inst.u.upper[19]}}, i_inst.u.upper[7:0],
                  i_inst.u.upper[8], i_inst.u.upper[18:9], 1'b0};

  always_comb begin
    o_imm             = '0;
    o_ctrl            = '0;
    o_ctrl.alu_op     = ALU_ADD;
    o_ctrl.src1_sel   = SRC1_RS1;
    o_ctrl.src2_sel   = SRC2_RS2;
    o_ctrl.mem_op     = funct3;
    o_br_ctrl         = '0;
    o_br_ctrl.br_func = br_func_e'(funct3);
    legal             = 1'b1;
    case (i_inst.r.opcode)
      OP_LUI: begin
        o_imm           = imm_u;
        o_ctrl.alu_op   = ALU_LUI;
        o_ctrl.src2_sel = SRC2_IMM;
        o_ctrl.gpr_wen  = 1'b1;
      end
      OP_AUIPC: begin
        o_imm           = imm_u;
        o_ctrl.src1_sel = SRC1_PC;
        o_ctrl.src2_sel = SRC2_IMM;
        o_ctrl.gpr_wen  = 1'b1;
      end
      OP_JAL, OP_JALR: begin  // link = pc + 4 through the alu
        o_imm           = (i_inst.r.opcode == OP_JAL) ? imm_j : imm_i;
        o_ctrl.src1_sel = SRC1_PC;
        o_ctrl.src2_sel = SRC2_FOUR;
        o_ctrl.gpr_wen  = 1'b1;
        o_br_ctrl.jal   = (i_inst.r.opcode == OP_JAL);
        o_br_ctrl.jalr  = (i_inst.r.opcode == OP_JALR);
        legal           = (i_inst.r.opcode == OP_JAL) || (funct3 == 3'b000);
      end
      OP_BRANCH: begin
        o_imm          = imm_b;
        o_br_ctrl.bren = 1'b1;
        legal          = (funct3[2:1] != 2'b01);
      end
      OP_LOAD: begin
        o_imm           = imm_i;
        o_ctrl.src2_sel = SRC2_IMM;
        o_ctrl.mem_ren  = 1'b1;
        o_ctrl.gpr_wen  = 1'b1;
        legal           = (funct3 != 3'b111);  // no ldu
      end
      OP_STORE: begin
        o_imm           = imm_s;
        o_ctrl.src2_sel = SRC2_IMM;
        o_ctrl.mem_wen  = 1'b1;
        legal           = !funct3[2];
      end
      OP_IMM, OP_IMM_32: begin
        o_imm           = imm_i;
        o_ctrl.src2_sel = SRC2_IMM;
        o_ctrl.gpr_wen  = 1'b1;
        o_ctrl.alu_op   = alu_op_of(funct3, funct7[5] && (funct3 == 3'b101));
        o_ctrl.word_cut = (i_inst.r.opcode == OP_IMM_32);
        if (i_inst.r.opcode == OP_IMM) begin
          // 6-bit shamt, funct7[0] belongs to it
          if (funct3 == 3'b001) begin
            legal = (funct7[6:1] == 6'b000000);
          end else if (funct3 == 3'b101) begin
            legal = (funct7[6:1] == 6'b000000) || (funct7[6:1] == 6'b010000);
          end
        end else begin
          legal = (funct3 == 3'b000) || (funct3 == 3'b001 && f7_zero) ||
                  (funct3 == 3'b101 && (f7_zero || f7_alt));
        end
      end
      OP_REG, OP_REG_32: begin
        o_ctrl.gpr_wen  = 1'b1;
        o_ctrl.alu_op   = alu_op_of(funct3, funct7[5]);
        o_ctrl.word_cut = (i_inst.r.opcode == OP_REG_32);
        legal = f7_zero || (f7_alt && (funct3 == 3'b000 || funct3 == 3'b101));
        if (i_inst.r.opcode == OP_REG_32) begin
          legal = legal && (funct3 == 3'b000 || funct3 == 3'b001 || funct3 == 3'b101);
        end
      end
      default: legal = 1'b0;  // system, fence, csr and the rest
    endcase
    if (!legal) begin
      o_ctrl.invalid  = 1'b1;
      o_ctrl.gpr_wen  = 1'b0;
      o_ctrl.mem_ren  = 1'b0;
      o_ctrl.mem_wen  = 1'b0;
      o_br_ctrl.bren  = 1'b0;
      o_br_ctrl.jal   = 1'b0;
      o_br_ctrl.jalr  = 1'b0;
    end
  end

endmodule

// ==== id_gpr_file.sv ====
// general register file, 32 x 64 bits, two combinational reads and one write
`include "id_stage_defines.svh"

module id_gpr_file import id_stage_pkg::*; (
  input  logic      i_clk,
  input  gpr_addr_t i_raddr1,
  input  gpr_addr_t i_raddr2,
  input  wb_t       i_wb,
  output xword_t    o_rdata1,
  output xword_t    o_rdata2
);

  xword_t regs [`ID_GPR_COUNT];

  // x0 is never written
  always_ff @(posedge i_clk) begin
    if (i_wb.wen && (i_wb.waddr != '0)) begin
      regs[i_wb.waddr] <= i_wb.wdata;
    end
  end

  // same-cycle write shows up next cycle, ws bypass covers the gap
  assign o_rdata1 = (i_raddr1 == '0) ? '0 : regs[i_raddr1];
  assign o_rdata2 = (i_raddr2 == '0) ? '0 : regs[i_raddr2];

endmodule

// ==== id_operand_bypass.sv ====
// operand forwarding from execute, memory and write-back, plus load-use detect
module id_operand_bypass import id_stage_pkg::*; (
  input  gpr_addr_t i_rs1,
  input  gpr_addr_t i_rs2,
  input  xword_t    i_rf_rdata1,
  input  xword_t    i_rf_rdata2,
  input  bypass_t   i_es,
  input  bypass_t   i_ms,
  input  bypass_t   i_ws,
  output xword_t    o_rs1data,
  output xword_t    o_rs2data,
  output logic      o_load_stall
);

  logic es_hit_rs1;
  logic es_hit_rs2;

  // youngest producer wins
  function automatic xword_t forward(input gpr_addr_t idx, input xword_t rf_data);
    if (i_es.rd != '0 && i_es.rd == idx) begin
      forward = i_es.result;
    end else if (i_ms.rd != '0 && i_ms.rd == idx) begin
      forward = i_ms.result;
    end else if (i_ws.rd != '0 && i_ws.rd == idx) begin
      forward = i_ws.result;
    end else begin
      forward = rf_data;
    end
  endfunction

  assign o_rs1data = forward(i_rs1, i_rf_rdata1);
  assign o_rs2data = forward(i_rs2, i_rf_rdata2);

  assign es_hit_rs1 = (i_es.rd != '0) && (i_es.rd == i_rs1);
  assign es_hit_rs2 = (i_es.rd != '0) && (i_es.rd == i_rs2);

  // load data only arrives from the memory stage, wait one cycle
  assign o_load_stall = i_es.load_sel && (es_hit_rs1 || es_hit_rs2);

endmodule

// ==== id_stage.f ====
+incdir+.
id_stage_pkg.sv
id_decoder.sv
id_gpr_file.sv
id_operand_bypass.sv
id_branch_unit.sv
id_stage.sv
tb_id_stage.sv

// ==== id_stage.sv ====
// decode stage top: stage register, handshake, gpr read, forwarding and branch redirect
module id_stage import id_stage_pkg::*; (
  input  logic      i_clk,
  input  logic      i_rst_n,
  // fetch to decode
  input  logic      i_fs_to_ds_valid,
  input  fs_to_ds_t i_fs_to_ds,
  output logic      o_ds_allowin,
  // decode to execute
  input  logic      i_es_allowin,
  output logic      o_ds_to_es_valid,
  output ds_to_es_t o_ds_to_es,
  // write back into the gpr file
  input  wb_t       i_wb,
  // forwarding
  input  bypass_t   i_es_bypass,
  input  bypass_t   i_ms_bypass,
  input  bypass_t   i_ws_bypass,
  // redirect to fetch
  output br_bus_t   o_br
);

  logic      ds_valid;
  logic      ds_ready_go;
  logic      load_stall;
  fs_to_ds_t ds_r;
  gpr_addr_t rs1;
  gpr_addr_t rs2;
  gpr_addr_t rd;
  xword_t    imm;
  xword_t    rf_rdata1;
  xword_t    rf_rdata2;
  xword_t    rs1data;
  xword_t    rs2data;
  ds_ctrl_t  ctrl;
  br_ctrl_t  br_ctrl;

  assign ds_ready_go      = !load_stall;
  assign o_ds_allowin     = !ds_valid || (ds_ready_go && i_es_allowin);
  assign o_ds_to_es_valid = ds_valid && ds_ready_go;

  // wrong-path item dropped while the redirect is out
  always_ff @(posedge i_clk) begin
    if (!i_rst_n) begin
      ds_valid <= 1'b0;
    end else if (o_ds_allowin) begin
      ds_valid <= i_fs_to_ds_valid && !o_br.taken;
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_fs_to_ds_valid && o_ds_allowin) begin
      ds_r <= i_fs_to_ds;
    end
  end

  id_decoder u_decoder (
    .i_inst    (ds_r.inst),
    .o_rs1     (rs1),
    .o_rs2     (rs2),
    .o_rd      (rd),
    .o_imm     (imm),
    .o_ctrl    (ctrl),
    .o_br_ctrl (br_ctrl)
  );

  id_gpr_file u_gpr_file (
    .i_clk    (i_clk),
    .i_raddr1 (rs1),
    .i_raddr2 (rs2),
    .i_wb     (i_wb),
    .o_rdata1 (rf_rdata1),
    .o_rdata2 (rf_rdata2)
  );

  id_operand_bypass u_operand_bypass (
    .i_rs1        (rs1),
    .i_rs2        (rs2),
    .i_rf_rdata1  (rf_rdata1),
    .i_rf_rdata2  (rf_rdata2),
    .i_es         (i_es_bypass),
    .i_ms         (i_ms_bypass),
    .i_ws         (i_ws_bypass),
    .o_rs1data    (rs1data),
    .o_rs2data    (rs2data),
    .o_load_stall (load_stall)
  );

  id_branch_unit u_branch_unit (
    .i_valid    (ds_valid && ds_ready_go),  // operands must be final
    .i_br_ctrl  (br_ctrl),
    .i_rs1data  (rs1data),
    .i_rs2data  (rs2data),
    .i_pc       (ds_r.pc),
    .i_imm      (imm),
    .i_fetch_pc (i_fs_to_ds.pc),
    .o_br       (o_br)
  );

  assign o_ds_to_es.ctrl    = ctrl;
  assign o_ds_to_es.rs1data = rs1data;
  assign o_ds_to_es.rs2data = rs2data;
  assign o_ds_to_es.imm     = imm;
  assign o_ds_to_es.pc      = ds_r.pc;
  assign o_ds_to_es.rd      = rd;

endmodule

// ==== id_stage_defines.svh ====
// width macros for the instruction decode stage of the rv64i pipeline
`ifndef ID_STAGE_DEFINES_SVH
`define ID_STAGE_DEFINES_SVH

// datapath
`define ID_XLEN        64  // gpr and pc width
`define ID_INST_WD     32

// register file
`define ID_GPR_ADDR_WD 5
`define ID_GPR_COUNT   32

// instruction fields
`define ID_OPCODE_WD   7
`define ID_FUNCT3_WD   3

// control encodings
`define ID_ALU_OP_WD   4
`define ID_SRC2_WD     2   // rs2, imm or four

`endif

// ==== id_stage_pkg.sv ====
// types shared by the decode stage: instruction views, stage buses and op encodings
`include "id_stage_defines.svh"

package id_stage_pkg;

  typedef logic [`ID_XLEN-1:0]        xword_t;
  typedef logic [`ID_GPR_ADDR_WD-1:0] gpr_addr_t;

  // one instruction word, read as r/i/s/b fields or as u/j fields
  typedef union packed {
    struct packed {
      logic [6:0]               funct7;  // imm high bits for i/s/b
      gpr_addr_t                rs2;
      gpr_addr_t                rs1;
      logic [`ID_FUNCT3_WD-1:0] funct3;
      gpr_addr_t                rd;      // imm low bits for s/b
      logic [`ID_OPCODE_WD-1:0] opcode;
    } r;
    struct packed {
      logic [`ID_INST_WD-`ID_GPR_ADDR_WD-`ID_OPCODE_WD-1:0] upper;
      gpr_addr_t                                            rd;
      logic [`ID_OPCODE_WD-1:0]                             opcode;
    } u;
  } inst_u;

  typedef enum logic [`ID_OPCODE_WD-1:0] {
    OP_LUI    = 7'b0110111,
    OP_AUIPC  = 7'b0010111,
    OP_JAL    = 7'b1101111,
    OP_JALR   = 7'b1100111,
    OP_BRANCH = 7'b1100011,
    OP_LOAD   = 7'b0000011,
    OP_STORE  = 7'b0100011,
    OP_IMM    = 7'b0010011,
    OP_IMM_32 = 7'b0011011,
    OP_REG    = 7'b0110011,
    OP_REG_32 = 7'b0111011
  } opcode_e;

  typedef enum logic [`ID_ALU_OP_WD-1:0] {
    ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU, ALU_XOR,
    ALU_SRL, ALU_SRA, ALU_OR, ALU_AND, ALU_LUI
  } alu_op_e;

  typedef enum logic {SRC1_RS1, SRC1_PC} src1_e;
  typedef enum logic [`ID_SRC2_WD-1:0] {SRC2_RS2, SRC2_IMM, SRC2_FOUR} src2_e;

  // same encoding as funct3 of the branch opcode
  typedef enum logic [`ID_FUNCT3_WD-1:0] {
    BR_EQ  = 3'b000,
    BR_NE  = 3'b001,
    BR_LT  = 3'b100,
    BR_GE  = 3'b101,
    BR_LTU = 3'b110,
    BR_GEU = 3'b111
  } br_func_e;

  typedef struct packed {
    inst_u  inst;
    xword_t pc;
  } fs_to_ds_t;

  typedef struct packed {
    logic      wen;
    gpr_addr_t waddr;
    xword_t    wdata;
  } wb_t;

  typedef struct packed {
    gpr_addr_t rd;        // zero when the stage has no result
    xword_t    result;
    logic      load_sel;  // result not ready yet, execute stage only
  } bypass_t;

  typedef struct packed {
    logic     bren;
    logic     jal;
    logic     jalr;
    br_func_e br_func;
  } br_ctrl_t;

  typedef struct packed {
    alu_op_e                  alu_op;
    src1_e                    src1_sel;
    src2_e                    src2_sel;
    logic                     word_cut;
    logic                     gpr_wen;
    logic                     mem_ren;
    logic                     mem_wen;
    logic [`ID_FUNCT3_WD-1:0] mem_op;
    logic                     invalid;
  } ds_ctrl_t;

  typedef struct packed {
    ds_ctrl_t  ctrl;
    xword_t    rs1data;
    xword_t    rs2data;
    xword_t    imm;
    xword_t    pc;
    gpr_addr_t rd;
  } ds_to_es_t;

  typedef struct packed {
    logic   taken;
    xword_t target;
  } br_bus_t;

endpackage

// ==== tb_id_stage_tests.svh ====
// directed tests for decode, forwarding, load-use, branches and back-pressure of the decode stage

  function automatic inst_u enc_r(input logic [6:0] f7, input gpr_addr_t rs2,
                                  input gpr_addr_t rs1, input logic [2:0] f3,
                                  input gpr_addr_t rd, input logic [6:0] opc);
    enc_r = {f7, rs2, rs1, f3, rd, opc};
  endfunction

  function automatic inst_u enc_i(input logic [11:0] imm, input gpr_addr_t rs1,
                                  input logic [2:0] f3, input gpr_addr_t rd,
                                  input logic [6:0] opc);
    enc_i = {imm, rs1, f3, rd, opc};
  endfunction

  // imm bit 0 is implied zero
  function automatic inst_u enc_b(input logic [12:0] imm, input gpr_addr_t rs2,
                                  input gpr_addr_t rs1, input logic [2:0] f3);
    enc_b = {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'b1100011};
  endfunction

  function automatic inst_u enc_u(input logic [19:0] upper, input gpr_addr_t rd,
                                  input logic [6:0] opc);
    enc_u = {upper, rd, opc};
  endfunction

  function automatic inst_u enc_j(input logic [20:0] imm, input gpr_addr_t rd);
    enc_j = {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
  endfunction

  // memory enables stay clear for everything sent here
  function automatic ds_ctrl_t make_ctrl(input alu_op_e op, input src1_e s1, input src2_e s2,
                                         input logic wcut, input logic wen,
                                         input logic [2:0] f3, input logic inv);
    make_ctrl = '{op, s1, s2, wcut, wen, 1'b0, 1'b0, f3, inv};
  endfunction

  function automatic ds_to_es_t make_item(input ds_ctrl_t ctrl, input xword_t rs1data,
                                          input xword_t rs2data, input xword_t imm,
                                          input xword_t pc, input gpr_addr_t rd);
    make_item = '{ctrl, rs1data, rs2data, imm, pc, rd};
  endfunction

  task automatic test_decode_alu();
    string       name;
    logic [11:0] imm12;
    logic [19:0] upper;
    ds_ctrl_t    ctrl;
    name       = "test_decode_alu";
    es_allowin = 1'b1;
    for (int i = 1; i < 32; i++) begin
      write_gpr(gpr_addr_t'(i), {$random(seed), $random(seed)});
    end
    // addi x4, x1, imm whose low bits double as the rs2 field
    imm12 = 12'($random(seed));
    send_inst(enc_i(imm12, 5'd1, 3'b000, 5'd4, OP_IMM), 64'h1000);
    wait_out(name);
    ctrl = make_ctrl(ALU_ADD, SRC1_RS1, SRC2_IMM, 1'b0, 1'b1, 3'b000, 1'b0);
    check_ds_to_es(name, make_item(ctrl, gpr_model[1], gpr_model[imm12[4:0]],
                                   {{52{imm12[11]}}, imm12}, 64'h1000, 5'd4), ds_to_es);
    // add x6, x0, x2
    send_inst(enc_r(7'b0000000, 5'd2, 5'd0, 3'b000, 5'd6, OP_REG), 64'h1004);
    wait_out(name);
    ctrl = make_ctrl(ALU_ADD, SRC1_RS1, SRC2_RS2, 1'b0, 1'b1, 3'b000, 1'b0);
    check_ds_to_es(name, make_item(ctrl, 64'd0, gpr_model[2], 64'd0, 64'h1004, 5'd6),
                   ds_to_es);
    // subw x7, x3, x5
    send_inst(enc_r(7'b0100000, 5'd5, 5'd3, 3'b000, 5'd7, OP_REG_32), 64'h1008);
    wait_out(name);
    ctrl = make_ctrl(ALU_SUB, SRC1_RS1, SRC2_RS2, 1'b1, 1'b1, 3'b000, 1'b0);
    check_ds_to_es(name, make_item(ctrl, gpr_model[3], gpr_model[5], 64'd0, 64'h1008, 5'd7),
                   ds_to_es);
    // lui x8 with rs1, rs2 and funct3 fields inside the upper immediate
    upper = 20'($random(seed));
    send_inst(enc_u(upper, 5'd8, OP_LUI), 64'h100c);
    wait_out(name);
    ctrl = make_ctrl(ALU_LUI, SRC1_RS1, SRC2_IMM, 1'b0, 1'b1, upper[2:0], 1'b0);
    check_ds_to_es(name, make_item(ctrl, gpr_model[upper[7:3]], gpr_model[upper[12:8]],
                                   {{32{upper[19]}}, upper, 12'h000}, 64'h100c, 5'd8),
                   ds_to_es);
    send_inst(32'h0000_0073, 64'h1010);  // ecall decodes to invalid
    wait_out(name);
    ctrl = make_ctrl(ALU_ADD, SRC1_RS1, SRC2_RS2, 1'b0, 1'b0, 3'b000, 1'b1);
    check_ds_to_es(name, make_item(ctrl, 64'd0, 64'd0, 64'd0, 64'h1010, 5'd0), ds_to_es);
  endtask

  task automatic test_bypass();
    string     name;
    xword_t    va;
    xword_t    vb;
    xword_t    vc;
    ds_to_es_t exp;
    name = "test_bypass";
    va   = {$random(seed), $random(seed)};
    vb   = {$random(seed), $random(seed)};
    vc   = {$random(seed), $random(seed)};
    send_inst(enc_r(7'b0000000, 5'd0, 5'd1, 3'b000, 5'd9, OP_REG), 64'h2000);
    es_allowin = 1'b0;  // hold add x9, x1, x0 in the stage
    wait_out(name);
    exp = make_item(make_ctrl(ALU_ADD, SRC1_RS1, SRC2_RS2, 1'b0, 1'b1, 3'b000, 1'b0),
                    gpr_model[1], 64'd0, 64'd0, 64'h2000, 5'd9);
    check_ds_to_es(name, exp, ds_to_es);
    check_bit(name, 1'b0, ds_allowin);
    next_cycle();
    es_bypass = '{5'd1, va, 1'b0};
    ms_bypass = '{5'd1, vb, 1'b0};
    ws_bypass = '{5'd1, vc, 1'b0};
    settle();
    exp.rs1data = va;
    check_ds_to_es(name, exp, ds_to_es);
    next_cycle();
    es_bypass.rd = 5'd0;  // va must not reach x0
    settle();
    exp.rs1data = vb;
    check_ds_to_es(name, exp, ds_to_es);
    next_cycle();
    ms_bypass.rd = 5'd0;
    settle();
    exp.rs1data = vc;
    check_ds_to_es(name, exp, ds_to_es);
    next_cycle();
    ws_bypass.rd = 5'd0;
    settle();
    exp.rs1data = gpr_model[1];
    check_ds_to_es(name, exp, ds_to_es);
    next_cycle();
    clear_bypass();
    es_allowin = 1'b1;
  endtask

  task automatic test_load_stall();
    string  name;
    xword_t vl;
    name      = "test_load_stall";
    vl        = {$random(seed), $random(seed)};
    es_bypass = '{5'd5, vl, 1'b1};  // load into x5 sits in execute
    send_inst(enc_r(7'b0000000, 5'd5, 5'd3, 3'b000, 5'd10, OP_REG), 64'h2100);
    repeat (3) begin
      settle();
      check_bit(name, 1'b0, ds_to_es_valid);
      check_bit(name, 1'b0, ds_allowin);
      next_cycle();
    end
    es_bypass = '0;
    ms_bypass = '{5'd5, vl, 1'b0};  // load data now in memory stage
    wait_out(name);
    check_ds_to_es(name, make_item(make_ctrl(ALU_ADD, SRC1_RS1, SRC2_RS2, 1'b0, 1'b1,
                                             3'b000, 1'b0),
                                   gpr_model[3], vl, 64'd0, 64'h2100, 5'd10), ds_to_es);
    next_cycle();
    clear_bypass();
  endtask

  task automatic test_branch();
    string  name;
    xword_t v;
    name       = "test_branch";
    es_allowin = 1'b1;
    v          = {$random(seed), $random(seed)} >> 1;
    write_gpr(5'd13, v);
    write_gpr(5'd14, v | 64'h8000_0000_0000_0000);  // sign bit set so bltu and blt disagree
    // taken beq x13, x13 with a wrong-path item offered
    send_inst(enc_b(13'd64, 5'd13, 5'd13, 3'b000), 64'h3000);
    fs_to_ds_valid = 1'b1;
    fs_to_ds       = '{enc_i(12'd1, 5'd0, 3'b000, 5'd15, OP_IMM), 64'h3004};
    settle();
    check_br(name, br_bus_t'{1'b1, 64'h3040}, br);
    check_bit(name, 1'b1, ds_to_es_valid);
    next_cycle();
    fs_to_ds_valid = 1'b0;
    settle();
    check_bit(name, 1'b0, ds_to_es_valid);  // wrong path dropped
    send_inst(enc_b(-13'sd16, 5'd14, 5'd13, 3'b000), 64'h3100);
    settle();
    check_br(name, br_bus_t'{1'b0, 64'h30f0}, br);
    send_inst(enc_b(13'd32, 5'd14, 5'd13, 3'b110), 64'h3200);  // bltu
    settle();
    check_br(name, br_bus_t'{1'b1, 64'h3220}, br);
    send_inst(enc_j(21'h100, 5'd1), 64'h3300);
    es_allowin  = 1'b0;
    fs_to_ds.pc = 64'h3400;  // fetch already on the target
    settle();
    check_br(name, br_bus_t'{1'b0, 64'h3400}, br);
    next_cycle();
    fs_to_ds.pc = 64'h3304;
    settle();
    check_br(name, br_bus_t'{1'b1, 64'h3400}, br);
    next_cycle();
    es_allowin = 1'b1;
    send_inst(enc_i(12'd7, 5'd13, 3'b000, 5'd1, OP_JALR), 64'h3500);
    settle();
    check_br(name, br_bus_t'{1'b1, (v + 64'd7) & ~64'd1}, br);
  endtask

  task automatic test_backpressure();
    string     name;
    ds_to_es_t exp_a;
    ds_to_es_t exp_b;
    name  = "test_backpressure";
    exp_a = make_item(make_ctrl(ALU_ADD, SRC1_RS1, SRC2_IMM, 1'b0, 1'b1, 3'b000, 1'b0),
                      gpr_model[1], gpr_model[4], 64'd100, 64'h4000, 5'd16);
    exp_b = make_item(make_ctrl(ALU_ADD, SRC1_RS1, SRC2_IMM, 1'b0, 1'b1, 3'b000, 1'b0),
                      gpr_model[2], 64'd0, -64'sd128, 64'h4004, 5'd17);
    send_inst(enc_i(12'd100, 5'd1, 3'b000, 5'd16, OP_IMM), 64'h4000);
    es_allowin = 1'b0;
    wait_out(name);
    next_cycle();
    fs_to_ds_valid = 1'b1;
    fs_to_ds       = '{enc_i(12'hf80, 5'd2, 3'b000, 5'd17, OP_IMM), 64'h4004};
    repeat (3) begin
      settle();
      check_ds_to_es(name, exp_a, ds_to_es);
      check_bit(name, 1'b0, ds_allowin);
      next_cycle();
    end
    es_allowin = 1'b1;
    settle();
    check_bit(name, 1'b1, ds_allowin);
    next_cycle();
    fs_to_ds_valid = 1'b0;
    wait_out(name);
    check_ds_to_es(name, exp_b, ds_to_es);
    // taken jal held in the stage through a reset
    send_inst(enc_j(21'h100, 5'd1), 64'h4100);
    es_allowin = 1'b0;
    settle();
    check_br(name, br_bus_t'{1'b1, 64'h4200}, br);
    apply_reset();
    settle();
    check_bit(name, 1'b0, ds_to_es_valid);
    check_bit(name, 1'b1, ds_allowin);
    check_br(name, br_bus_t'{1'b0, 64'h4200}, br);
    es_allowin = 1'b1;
  endtask

// ==== tb_id_stage.sv ====
// testbench top for the decode stage: clock, reset, DUT, compare tasks and watchdog
module tb_id_stage import id_stage_pkg::*; ();

  localparam int CLK_PERIOD      = 100;
  localparam int DRIVE_DELAY     = 10;
  localparam int SAMPLE_DELAY    = 20;
  localparam int NUM_TESTS       = 5;
  localparam int CYCLES_PER_TEST = 200;

  logic      clk;
  logic      rst_n;
  logic      fs_to_ds_valid;
  fs_to_ds_t fs_to_ds;
  logic      es_allowin;
  wb_t       wb;
  bypass_t   es_bypass;
  bypass_t   ms_bypass;
  bypass_t   ws_bypass;
  logic      ds_allowin;
  logic      ds_to_es_valid;
  ds_to_es_t ds_to_es;
  br_bus_t   br;

  int        seed = 71477;
  xword_t    gpr_model [32];  // what the register file should hold

  id_stage u_id_stage (
    .i_clk            (clk),
    .i_rst_n          (rst_n),
    .i_fs_to_ds_valid (fs_to_ds_valid),
    .i_fs_to_ds       (fs_to_ds),
    .o_ds_allowin     (ds_allowin),
    .i_es_allowin     (es_allowin),
    .o_ds_to_es_valid (ds_to_es_valid),
    .o_ds_to_es       (ds_to_es),
    .i_wb             (wb),
    .i_es_bypass      (es_bypass),
    .i_ms_bypass      (ms_bypass),
    .i_ws_bypass      (ws_bypass),
    .o_br             (br)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  // inputs change just after the edge
  task automatic next_cycle();
    @(posedge clk);
    #(DRIVE_DELAY);
  endtask

  task automatic settle();
    #(SAMPLE_DELAY);
  endtask

  task automatic fail_run(input string msg);
    $display("%s", msg);
    $display("test failed");
    $fatal(1, "run stopped at the first failure");
  endtask

  task automatic check_ds_to_es(input string name, input ds_to_es_t exp, input ds_to_es_t act);
    if (act !== exp) begin
      fail_run($sformatf("ERROR %s: expected %h actual %h", name, exp, act));
    end
  endtask

  task automatic check_br(input string name, input br_bus_t exp, input br_bus_t act);
    if (act !== exp) begin
      fail_run($sformatf("ERROR %s: expected %h actual %h", name, exp, act));
    end
  endtask

  task automatic check_bit(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      fail_run($sformatf("ERROR %s: expected %b actual %b", name, exp, act));
    end
  endtask

  task automatic apply_reset();
    next_cycle();
    rst_n = 1'b0;
    repeat (5) next_cycle();
    rst_n = 1'b1;
  endtask

  task automatic write_gpr(input gpr_addr_t addr, input xword_t data);
    next_cycle();
    wb                = '{1'b1, addr, data};
    gpr_model[addr]   = data;
    next_cycle();
    wb.wen            = 1'b0;
  endtask

  task automatic clear_bypass();
    es_bypass = '0;
    ms_bypass = '0;
    ws_bypass = '0;
  endtask

  // offer one item and hold it until the stage takes it
  task automatic send_inst(input inst_u inst, input xword_t pc);
    int waited;
    waited = 0;
    next_cycle();
    fs_to_ds_valid = 1'b1;
    fs_to_ds.inst  = inst;
    fs_to_ds.pc    = pc;
    settle();
    while (!ds_allowin) begin
      waited++;
      if (waited > 50) begin
        fail_run("the decode stage never accepted the fetched instruction");
      end
      next_cycle();
      settle();
    end
    next_cycle();
    fs_to_ds_valid = 1'b0;
  endtask

  task automatic wait_out(input string name);
    int waited;
    waited = 0;
    settle();
    while (!ds_to_es_valid) begin
      waited++;
      if (waited > 20) begin
        fail_run($sformatf("%s: no instruction reached the execute stage", name));
      end
      next_cycle();
      settle();
    end
  endtask

  `include "tb_id_stage_tests.svh"

  initial begin : watchdog
    repeat (NUM_TESTS * CYCLES_PER_TEST + 10) @(posedge clk);
    fail_run("timeout: the tests did not finish within the cycle budget");
  end

  initial begin : main
    rst_n          = 1'b0;
    fs_to_ds_valid = 1'b0;
    fs_to_ds       = '0;
    es_allowin     = 1'b1;
    wb             = '0;
    gpr_model[0]   = '0;
    clear_bypass();
    apply_reset();
    test_decode_alu();
    test_bypass();
    test_load_stall();
    test_branch();
    test_backpressure();
    $display("test passed");
    $finish;
  end

endmodule
